// File: design/game_pkg.sv
`default_nettype none

package game_pkg;

    typedef logic [9:0] coord_t;

    typedef struct packed {
        coord_t h;
        coord_t v;
    } tile_pos_t;

    typedef enum logic [1:0] {
        dir_up    = 2'd0,
        dir_down  = 2'd1,
        dir_left  = 2'd2,
        dir_right = 2'd3
    } dir_t;

    // One keypad command word
    typedef struct packed {
        dir_t dir;
        logic move;
        logic attack;
    } key_cmd_t;

    typedef struct packed {
        tile_pos_t       player_pos;
        logic [3:0]      player_idx;   // Facing code
        tile_pos_t       monster_pos;
        logic [3:0]      monster_idx;
        logic [2:0][3:0] heart_idx;
        logic [3:0]      gameover_idx;
    } game_view_t;

    localparam coord_t TILE = 10'd20;

    // Border wall lines
    localparam coord_t FIELD_MIN_H = 10'd20;
    localparam coord_t FIELD_MAX_H = 10'd320;
    localparam coord_t FIELD_MIN_V = 10'd20;
    localparam coord_t FIELD_MAX_V = 10'd220;

    localparam int N_INNER = 11;
    localparam tile_pos_t INNER_WALLS [N_INNER] = '{
        '{h: 10'd280, v: 10'd80},  '{h: 10'd260, v: 10'd80},  '{h: 10'd260, v: 10'd100},
        '{h: 10'd260, v: 10'd60},  '{h: 10'd240, v: 10'd80},  '{h: 10'd160, v: 10'd160},
        '{h: 10'd180, v: 10'd160}, '{h: 10'd200, v: 10'd160}, '{h: 10'd180, v: 10'd140},
        '{h: 10'd120, v: 10'd120}, '{h: 10'd100, v: 10'd100}
    };

    localparam logic [1:0] LIVES_MAX = 2'd3;

    localparam logic [3:0] SPRITE_HIDDEN = 4'hf;   // Not drawn
    localparam logic [3:0] SPRITE_SHOWN  = 4'h0;

    // Default tiles for the top-level parameters
    localparam tile_pos_t START_POS_DEF   = '{h: 10'd60, v: 10'd120};
    localparam tile_pos_t MONSTER_POS_DEF = '{h: 10'd100, v: 10'd160};

endpackage

`default_nettype wire

// File: design/wall_map.sv
`default_nettype none

module wall_map (
    input  wire game_pkg::tile_pos_t tile,
    output logic                     is_wall
);

    logic border;
    logic inner;

    assign border = (tile.h == game_pkg::FIELD_MIN_H) || (tile.h == game_pkg::FIELD_MAX_H) ||
                    (tile.v == game_pkg::FIELD_MIN_V) || (tile.v == game_pkg::FIELD_MAX_V);

    // Compare against every inner wall tile
    always_comb begin
        inner = 1'b0;
        for (int i = 0; i < game_pkg::N_INNER; i++) begin
            if (tile == game_pkg::INNER_WALLS[i]) begin
                inner = 1'b1;
            end
        end
    end

    assign is_wall = border || inner;

endmodule

`default_nettype wire

// File: design/monster_unit.sv
`default_nettype none

module monster_unit #(
    parameter game_pkg::tile_pos_t MONSTER_POS = game_pkg::MONSTER_POS_DEF
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                step,
    input  wire game_pkg::tile_pos_t target,
    input  wire logic                attack,
    input  wire game_pkg::tile_pos_t attack_tile,
    output logic                     contact,
    output logic                     alive,
    output game_pkg::tile_pos_t      pos
);

    logic hit;

    // Weapon lands on the monster tile
    assign hit = step && attack && (attack_tile == MONSTER_POS);

    always_ff @(posedge clk) begin
        if (rst) begin
            alive <= 1'b1;
        end else if (hit) begin
            alive <= 1'b0;   // Stays dead until reset
        end
    end

    assign contact = alive && (target == MONSTER_POS);
    assign pos     = MONSTER_POS;   // Stationary

endmodule

`default_nettype wire

// File: design/key_cmd_port.sv
`default_nettype none

module key_cmd_port (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               req,
    input  wire game_pkg::key_cmd_t cmd,
    input  wire logic               step_done,
    output logic                    ack,
    output logic                    cmd_valid,
    output game_pkg::key_cmd_t      cmd_word
);

    typedef enum logic [1:0] {
        idle,
        busy,
        hold
    } state_t;

    state_t state;
    logic   req_q;   // Sampled req from the keypad side

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            req_q     <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            req_q     <= req;
            cmd_valid <= 1'b0;
            case (state)
                idle: if (req_q) begin   // Only reached with req and ack both low
                    state     <= busy;
                    cmd_valid <= 1'b1;
                end
                busy: if (step_done) state <= hold;
                hold: if (!req_q) state <= idle;   // Controller released req
                default: state <= idle;
            endcase
        end
    end

    // Command stays stable while req is high
    always_ff @(posedge clk) begin
        if (state == idle && req_q) begin
            cmd_word <= cmd;
        end
    end

    assign ack = (state == hold);

endmodule

`default_nettype wire

// File: design/player_engine.sv
`default_nettype none

module player_engine #(
    parameter game_pkg::tile_pos_t START_POS   = game_pkg::START_POS_DEF,
    parameter game_pkg::tile_pos_t MONSTER_POS = game_pkg::MONSTER_POS_DEF
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               cmd_valid,
    input  wire game_pkg::key_cmd_t cmd_word,
    output logic                    step_done,
    output game_pkg::tile_pos_t     player_pos,
    output game_pkg::dir_t          facing,
    output logic [1:0]              lives,
    output logic                    gameover,
    output logic                    monster_alive,
    output game_pkg::tile_pos_t     monster_pos
);

    game_pkg::tile_pos_t next_tile;
    game_pkg::tile_pos_t face_tile;
    logic                is_wall;
    logic                contact;
    logic                active;

    // Neighbour tile one step away
    function automatic game_pkg::tile_pos_t step_tile(
        input game_pkg::tile_pos_t pos,
        input game_pkg::dir_t      dir
    );
        game_pkg::tile_pos_t t;
        t = pos;
        case (dir)
            game_pkg::dir_up:    t.v = pos.v - game_pkg::TILE;
            game_pkg::dir_down:  t.v = pos.v + game_pkg::TILE;
            game_pkg::dir_left:  t.h = pos.h - game_pkg::TILE;
            default:             t.h = pos.h + game_pkg::TILE;
        endcase
        return t;
    endfunction

    assign next_tile = step_tile(player_pos, cmd_word.dir);
    assign face_tile = step_tile(player_pos, facing);   // Attack goes where we already look
    assign active    = cmd_valid && !gameover;

    wall_map wall_map0 (
        .tile    (next_tile),
        .is_wall (is_wall)
    );

    monster_unit #(
        .MONSTER_POS (MONSTER_POS)
    ) monster0 (
        .clk         (clk),
        .rst         (rst),
        .step        (active),
        .target      (next_tile),
        .attack      (cmd_word.attack),
        .attack_tile (face_tile),
        .contact     (contact),
        .alive       (monster_alive),
        .pos         (monster_pos)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            step_done  <= 1'b0;
            player_pos <= START_POS;
            facing     <= game_pkg::dir_right;
            lives      <= game_pkg::LIVES_MAX;
            gameover   <= 1'b0;
        end else begin
            step_done <= cmd_valid;   // Also in game over
            if (active && cmd_word.move) begin
                facing <= cmd_word.dir;
                if (!is_wall) begin
                    if (contact) begin
                        player_pos <= START_POS;
                        lives      <= lives - 2'd1;
                        if (lives == 2'd1) begin
                            gameover <= 1'b1;
                        end
                    end else begin
                        player_pos <= next_tile;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/sprite_out.sv
`default_nettype none

module sprite_out (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                step_done,
    input  wire game_pkg::tile_pos_t player_pos,
    input  wire game_pkg::dir_t      facing,
    input  wire logic [1:0]          lives,
    input  wire logic                gameover,
    input  wire logic                monster_alive,
    input  wire game_pkg::tile_pos_t monster_pos,
    output game_pkg::game_view_t     view
);

    game_pkg::game_view_t next_view;
    logic                 refresh;

    always_comb begin
        next_view.player_pos  = player_pos;
        next_view.player_idx  = {2'b00, facing};
        next_view.monster_pos = monster_pos;
        next_view.monster_idx = monster_alive ? game_pkg::SPRITE_SHOWN : game_pkg::SPRITE_HIDDEN;
        for (int i = 0; i < 3; i++) begin
            next_view.heart_idx[i] = (lives > 2'(i)) ? game_pkg::SPRITE_SHOWN
                                                     : game_pkg::SPRITE_HIDDEN;
        end
        next_view.gameover_idx = gameover ? game_pkg::SPRITE_SHOWN : game_pkg::SPRITE_HIDDEN;
    end

    // High on the first edge after reset releases
    always_ff @(posedge clk) begin
        if (rst) begin
            refresh <= 1'b1;
        end else begin
            refresh <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (step_done || refresh) begin
            view <= next_view;   // Lands on the same edge as ack
        end
    end

endmodule

`default_nettype wire

// File: design/game_top.sv
`default_nettype none

module game_top #(
    parameter game_pkg::tile_pos_t START_POS   = game_pkg::START_POS_DEF,
    parameter game_pkg::tile_pos_t MONSTER_POS = game_pkg::MONSTER_POS_DEF
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               req,
    input  wire game_pkg::key_cmd_t cmd,
    output logic                    ack,
    output game_pkg::game_view_t    view
);

    logic                cmd_valid;
    game_pkg::key_cmd_t  cmd_word;
    logic                step_done;
    game_pkg::tile_pos_t player_pos;
    game_pkg::dir_t      facing;
    logic [1:0]          lives;
    logic                gameover;
    logic                monster_alive;
    game_pkg::tile_pos_t monster_pos;

    key_cmd_port key_port0 (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .cmd       (cmd),
        .step_done (step_done),
        .ack       (ack),
        .cmd_valid (cmd_valid),
        .cmd_word  (cmd_word)
    );

    player_engine #(
        .START_POS   (START_POS),
        .MONSTER_POS (MONSTER_POS)
    ) engine0 (
        .clk           (clk),
        .rst           (rst),
        .cmd_valid     (cmd_valid),
        .cmd_word      (cmd_word),
        .step_done     (step_done),
        .player_pos    (player_pos),
        .facing        (facing),
        .lives         (lives),
        .gameover      (gameover),
        .monster_alive (monster_alive),
        .monster_pos   (monster_pos)
    );

    sprite_out sprite0 (
        .clk           (clk),
        .rst           (rst),
        .step_done     (step_done),
        .player_pos    (player_pos),
        .facing        (facing),
        .lives         (lives),
        .gameover      (gameover),
        .monster_alive (monster_alive),
        .monster_pos   (monster_pos),
        .view          (view)
    );

endmodule

`default_nettype wire

// File: tests/game_asserts.sv
`default_nettype none

module game_asserts (
    input wire logic clk,
    input wire logic rst,
    input wire logic req,
    input wire logic ack
);

    int fail_count = 0;   // Failed assertions seen so far

    // Samples are taken before each edge, so a DUT edge count of N shows as N+1 here
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req, 4))
        else begin
            fail_count++;
            $error("ack rose without a request seen three edges before");
        end

    ack_rise_time: assert property (@(posedge clk) disable iff (rst)
        ($past(req, 4) && !$past(req, 5)) |-> $rose(ack))
        else begin
            fail_count++;
            $error("ack did not rise three edges after req was sampled high");
        end

    // Release side of the handshake
    ack_fall_time: assert property (@(posedge clk) disable iff (rst)
        (!$past(req, 2) && $past(req, 3)) |-> $fell(ack))
        else begin
            fail_count++;
            $error("ack did not fall one edge after req was sampled low");
        end

    ack_reset_low: assert property (@(posedge clk)
        rst |=> !ack)
        else begin
            fail_count++;
            $error("ack high right after a reset edge");
        end

endmodule

// Handshake checks on the DUT
bind game_top game_asserts asserts0 (
    .clk (clk),
    .rst (rst),
    .req (req),
    .ack (ack)
);

`default_nettype wire

// File: tests/game_tb.sv
`default_nettype none

module game_tb;

    localparam int RESET_CYCLES = 8;
    localparam int N_CMDS       = 29;
    localparam int HOLD_CYCLES  = 5;
    localparam int MAX_CYCLES   = 3 * (RESET_CYCLES + 3) + N_CMDS * 8 + HOLD_CYCLES + 64;

    localparam int SHOWN  = 0;
    localparam int HIDDEN = 15;

    localparam game_pkg::tile_pos_t START_POS   = '{h: 10'd60, v: 10'd120};
    localparam game_pkg::tile_pos_t MONSTER_POS = '{h: 10'd100, v: 10'd160};

    logic                 clk;
    logic                 rst;
    logic                 req;
    game_pkg::key_cmd_t   cmd;
    logic                 ack;
    game_pkg::game_view_t view;

    int cycles = 0;
    int checks;
    int errors;
    int assert_errors;
    int exp_lives;   // Expected hidden state, tracked from the game rules
    bit exp_alive;
    bit exp_over;

    game_top #(
        .START_POS   (START_POS),
        .MONSTER_POS (MONSTER_POS)
    ) dut0 (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .cmd  (cmd),
        .ack  (ack),
        .view (view)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the handshake did not complete", cycles);
            $display("test failed");
            $finish;
        end
    end

    task automatic expect_equal(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_view(input string name, input int h, input int v,
                              input game_pkg::dir_t face);
        expect_equal({name, " player h"}, h, int'(view.player_pos.h));
        expect_equal({name, " player v"}, v, int'(view.player_pos.v));
        expect_equal({name, " player idx"}, int'(face), int'(view.player_idx));
        expect_equal({name, " monster h"}, int'(MONSTER_POS.h), int'(view.monster_pos.h));
        expect_equal({name, " monster v"}, int'(MONSTER_POS.v), int'(view.monster_pos.v));
        expect_equal({name, " monster idx"}, exp_alive ? SHOWN : HIDDEN,
                     int'(view.monster_idx));
        for (int i = 0; i < 3; i++) begin
            expect_equal($sformatf("%s heart %0d", name, i), (exp_lives > i) ? SHOWN : HIDDEN,
                         int'(view.heart_idx[i]));
        end
        expect_equal({name, " gameover idx"}, exp_over ? SHOWN : HIDDEN,
                     int'(view.gameover_idx));
    endtask

    task automatic wait_ack(input logic level);
        do begin
            @(negedge clk);   // Outputs settled mid-cycle
        end while (ack !== level);
    endtask

    // First half of the four-phase exchange
    task automatic raise_req(input game_pkg::dir_t step_dir, input logic do_move,
                             input logic do_attack);
        @(posedge clk);
        cmd <= '{dir: step_dir, move: do_move, attack: do_attack};
        req <= 1'b1;
        wait_ack(1'b1);
    endtask

    task automatic release_req;
        @(posedge clk);
        req <= 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic send_cmd(input game_pkg::dir_t step_dir, input logic do_move,
                            input logic do_attack);
        raise_req(step_dir, do_move, do_attack);
        release_req();
    endtask

    task automatic move_and_check(input string name, input game_pkg::dir_t step_dir,
                                  input int h, input int v, input game_pkg::dir_t face);
        send_cmd(step_dir, 1'b1, 1'b0);
        check_view(name, h, v, face);
    endtask

    task automatic apply_reset;
        @(posedge clk);
        rst <= 1'b1;
        req <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        exp_lives = 3;
        exp_alive = 1'b1;
        exp_over  = 1'b0;
        @(posedge clk);   // View loads here
        @(negedge clk);
        expect_equal("reset ack", 0, int'(ack));
        check_view("reset", int'(START_POS.h), int'(START_POS.v), game_pkg::dir_right);
    endtask

    initial begin
        rst    = 1'b1;
        req    = 1'b0;
        cmd    = '0;
        checks = 0;
        errors = 0;
        apply_reset();

        // Back-pressure on the first command, then free moves and walls
        raise_req(game_pkg::dir_up, 1'b1, 1'b0);
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            expect_equal("held req ack", 1, int'(ack));
            check_view("held req", 60, 100, game_pkg::dir_up);
        end
        release_req();
        check_view("released req", 60, 100, game_pkg::dir_up);
        move_and_check("free right", game_pkg::dir_right, 80, 100, game_pkg::dir_right);
        move_and_check("free down", game_pkg::dir_down, 80, 120, game_pkg::dir_down);
        move_and_check("free up", game_pkg::dir_up, 80, 100, game_pkg::dir_up);
        move_and_check("inner wall", game_pkg::dir_right, 80, 100, game_pkg::dir_right);
        move_and_check("free left", game_pkg::dir_left, 60, 100, game_pkg::dir_left);
        move_and_check("free left 2", game_pkg::dir_left, 40, 100, game_pkg::dir_left);
        move_and_check("border wall", game_pkg::dir_left, 40, 100, game_pkg::dir_left);

        // Walk into the live monster three times
        apply_reset();
        for (int n = 1; n <= 3; n++) begin
            move_and_check("path 1", game_pkg::dir_down, 60, 140, game_pkg::dir_down);
            move_and_check("path 2", game_pkg::dir_down, 60, 160, game_pkg::dir_down);
            move_and_check("path 3", game_pkg::dir_right, 80, 160, game_pkg::dir_right);
            exp_lives--;
            exp_over = (exp_lives == 0);
            move_and_check($sformatf("contact %0d", n), game_pkg::dir_right,
                           int'(START_POS.h), int'(START_POS.v), game_pkg::dir_right);
        end
        move_and_check("after game over", game_pkg::dir_down, 60, 120, game_pkg::dir_right);

        // Attacks next to the monster, then step onto it once dead
        apply_reset();
        move_and_check("attack path 1", game_pkg::dir_down, 60, 140, game_pkg::dir_down);
        move_and_check("attack path 2", game_pkg::dir_right, 80, 140, game_pkg::dir_right);
        move_and_check("attack path 3", game_pkg::dir_down, 80, 160, game_pkg::dir_down);
        send_cmd(game_pkg::dir_right, 1'b0, 1'b1);   // Facing down, monster on the right
        check_view("attack away", 80, 160, game_pkg::dir_down);
        move_and_check("turn 1", game_pkg::dir_left, 60, 160, game_pkg::dir_left);
        move_and_check("turn 2", game_pkg::dir_right, 80, 160, game_pkg::dir_right);
        send_cmd(game_pkg::dir_up, 1'b0, 1'b1);
        exp_alive = 1'b0;
        check_view("attack hit", 80, 160, game_pkg::dir_right);
        move_and_check("onto dead monster", game_pkg::dir_right, 100, 160,
                       game_pkg::dir_right);

        assert_errors = dut0.asserts0.fail_count;
        $display("Checks: %0d, errors: %0d, assertion errors: %0d",
                 checks, errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
design/game_pkg.sv
design/wall_map.sv
design/monster_unit.sv
design/key_cmd_port.sv
design/player_engine.sv
design/sprite_out.sv
design/game_top.sv
tests/game_asserts.sv
tests/game_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the game testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 \
    --top-module game_tb \
    -f filelist.f \
    -o game_sim

./obj_dir/game_sim | tee sim.log

if grep -qx "test passed" sim.log; then
    exit 0
fi
exit 1
